// ==== verilog/pong_pkg.sv ====
package pong_pkg;

        // width of a pixel coordinate
        localparam int coord_w = 16;

        typedef struct packed {
                logic [7:0] red;
                logic [7:0] green;
                logic [7:0] blue;
        } rgb_t;

        // renderers use the raw word, the mixer splits it into channels
        typedef union packed {
                logic [23:0] raw;
                rgb_t        rgb;
        } pixel_color_u;

        // palette
        localparam logic [23:0] color_black = 24'h000000;
        localparam logic [23:0] color_blue  = 24'h0000ff;
        localparam logic [23:0] color_gray  = 24'hd3d3d3;
        localparam logic [23:0] color_white = 24'hffffff;
        localparam logic [23:0] color_red   = 24'hff0000;

endpackage

// ==== verilog/raster_if.sv ====
`timescale 1ns/1ns

interface raster_if
        import pong_pkg::*;
();

        logic [coord_w-1:0] pixel_x;
        logic [coord_w-1:0] pixel_y;
        // high inside the visible area
        logic               active;
        // both syncs active low
        logic               hsync;
        logic               vsync;

        modport source (output pixel_x, output pixel_y, output active,
                        output hsync, output vsync);

        modport sink (input pixel_x, input pixel_y, input active,
                      input hsync, input vsync);

endinterface

// ==== verilog/vga_timing.sv ====
`timescale 1ns/1ns

module vga_timing
        import pong_pkg::*;
#(
        parameter int h_active = 640,
        parameter int h_front  = 16,
        parameter int h_sync   = 96,
        parameter int h_back   = 48,
        parameter int v_active = 480,
        parameter int v_front  = 10,
        parameter int v_sync   = 2,
        parameter int v_back   = 33
) (
        input  logic     clk,
        input  logic     rst_n,
        raster_if.source raster
);

        localparam int h_total = h_active + h_front + h_sync + h_back;
        localparam int v_total = v_active + v_front + v_sync + v_back;

        localparam logic [coord_w-1:0] h_last       = coord_w'(h_total - 1);
        localparam logic [coord_w-1:0] v_last       = coord_w'(v_total - 1);
        localparam logic [coord_w-1:0] h_vis        = coord_w'(h_active);
        localparam logic [coord_w-1:0] v_vis        = coord_w'(v_active);
        localparam logic [coord_w-1:0] h_sync_start = coord_w'(h_active + h_front);
        localparam logic [coord_w-1:0] h_sync_end   = coord_w'(h_active + h_front + h_sync);
        localparam logic [coord_w-1:0] v_sync_start = coord_w'(v_active + v_front);
        localparam logic [coord_w-1:0] v_sync_end   = coord_w'(v_active + v_front + v_sync);

        logic [coord_w-1:0] h_cnt;
        logic [coord_w-1:0] v_cnt;
        logic [coord_w-1:0] h_next;
        logic [coord_w-1:0] v_next;

        // next raster position, vertical steps at end of line
        always_comb begin
                h_next = h_cnt + 1'b1;
                v_next = v_cnt;
                if (h_cnt == h_last) begin
                        h_next = '0;
                        if (v_cnt == v_last)
                                v_next = '0;
                        else
                                v_next = v_cnt + 1'b1;
                end
        end

        // syncs and active decoded from the next position so they
        // land in the same cycle as the counters
        always_ff @(posedge clk or negedge rst_n) begin
                if (!rst_n) begin
                        h_cnt         <= '0;
                        v_cnt         <= '0;
                        raster.hsync  <= 1'b1;
                        raster.vsync  <= 1'b1;
                        // pixel (0,0) is visible
                        raster.active <= 1'b1;
                end else begin
                        h_cnt         <= h_next;
                        v_cnt         <= v_next;
                        raster.hsync  <= !(h_next >= h_sync_start && h_next < h_sync_end);
                        raster.vsync  <= !(v_next >= v_sync_start && v_next < v_sync_end);
                        raster.active <= (h_next < h_vis) && (v_next < v_vis);
                end
        end

        assign raster.pixel_x = h_cnt;
        assign raster.pixel_y = v_cnt;

        // hsync pulse width
        a_hsync_width: assert property (@(posedge clk) disable iff (!rst_n)
                $fell(raster.hsync) |-> (!raster.hsync) [*h_sync] ##1 raster.hsync);

endmodule

// ==== verilog/paddle_sprite.sv ====
`timescale 1ns/1ns

module paddle_sprite
        import pong_pkg::*;
(
        raster_if.sink             raster,
        input  logic [coord_w-1:0] pos_x,
        input  logic [coord_w-1:0] pos_y,
        output logic               hit,
        output pixel_color_u       color
);

        // paddle box and quadrant fold points
        localparam logic [coord_w-1:0] span_x = 16'd101;
        localparam logic [coord_w-1:0] span_y = 16'd75;
        localparam logic [coord_w-1:0] fold_x = 16'd51;
        localparam logic [coord_w-1:0] fold_y = 16'd38;

        logic [coord_w-1:0] dx;
        logic [coord_w-1:0] dy;
        logic [coord_w-1:0] fx;
        logic [coord_w-1:0] fy;
        logic               in_box;
        logic [23:0]        art;

        // offsets from the top left corner
        assign dx = raster.pixel_x - pos_x;
        assign dy = raster.pixel_y - pos_y;

        // guard against wrap of the subtraction left of or above the paddle
        assign in_box = (raster.pixel_x >= pos_x) && (dx <= span_x) &&
                        (raster.pixel_y >= pos_y) && (dy <= span_y);

        // fold the other three quadrants onto the top left one
        assign fx = (dx <= fold_x) ? dx : span_x - dx;
        assign fy = (dy <= fold_y) ? dy : span_y - dy;

        // quarter of the bevelled art, walked in column bands
        always_comb begin
                art = color_black;
                if (fx <= 3) begin
                        // outer column, rounded corner on top
                        if (fy <= 3) begin
                                if (fx >= 2 && fy >= 2 && !(fx == 2 && fy == 2))
                                        art = color_blue;
                        end else if (fy <= 7) begin
                                if (!(fx == 0 && fy <= 5))
                                        art = color_blue;
                        end else begin
                                art = color_blue;
                        end
                end else if (fx <= 7) begin
                        if (fy <= 3) begin
                                if (!(fy == 0 && fx <= 5))
                                        art = color_blue;
                        end else if (fy <= 7) begin
                                // inner corner of the bevel
                                if ((fy == 7 && fx >= 6) || (fy == 6 && fx == 7))
                                        art = color_gray;
                                else
                                        art = color_blue;
                        end else if (fy <= 11) begin
                                if (fx == 4 && fy <= 9)
                                        art = color_blue;
                                else
                                        art = color_gray;
                        end else if (fy >= 37) begin
                                art = color_blue;
                        end else begin
                                art = color_gray;
                        end
                end else if (fx <= 11) begin
                        if (fy <= 3) begin
                                art = color_blue;
                        end else if (fy <= 7) begin
                                if (fy == 4 && fx <= 9)
                                        art = color_blue;
                                else
                                        art = color_gray;
                        end else if (fy >= 37) begin
                                art = color_blue;
                        end else begin
                                art = color_gray;
                        end
                end else if (fx <= 43) begin
                        // plain stretch, top edge and centre stripe
                        if (fy <= 3 || fy >= 37)
                                art = color_blue;
                        else
                                art = color_gray;
                end else if (fx <= 47) begin
                        if (fy <= 3) begin
                                art = color_blue;
                        end else if (fy >= 31 && fy <= 34) begin
                                // small notch where the stripes meet
                                if (fx >= 45 && fx <= 46 && fy >= 33)
                                        art = color_blue;
                                else if (fx >= 46 && fy >= 32 && fy <= 33)
                                        art = color_blue;
                                else
                                        art = color_gray;
                        end else if (fy >= 35) begin
                                if (fx <= 45)
                                        art = color_blue;
                                else
                                        art = color_gray;
                        end else begin
                                art = color_gray;
                        end
                end else begin
                        // columns next to the vertical centre line
                        if (fy <= 3)
                                art = color_blue;
                        else if (fx >= 50 && fy <= 30)
                                art = color_blue;
                        else if (fy >= 31 && fy <= 32)
                                art = color_blue;
                        else
                                art = color_gray;
                end
        end

        assign color.raw = in_box ? art : color_black;

        // bevel corners stay black and so do not count as a hit
        assign hit = (color.raw != color_black);

endmodule

// ==== verilog/ball_sprite.sv ====
`timescale 1ns/1ns

module ball_sprite
        import pong_pkg::*;
#(
        parameter int ball_size = 8
) (
        raster_if.sink             raster,
        input  logic [coord_w-1:0] pos_x,
        input  logic [coord_w-1:0] pos_y,
        output logic               hit,
        output pixel_color_u       color
);

        localparam logic [coord_w-1:0] ball_last = coord_w'(ball_size - 1);

        logic [coord_w-1:0] dx;
        logic [coord_w-1:0] dy;
        logic               in_ball;
        logic               on_rim;

        assign dx = raster.pixel_x - pos_x;
        assign dy = raster.pixel_y - pos_y;

        assign in_ball = (raster.pixel_x >= pos_x) && (dx <= ball_last) &&
                         (raster.pixel_y >= pos_y) && (dy <= ball_last);

        // outermost ring of the square
        assign on_rim = (dx == '0) || (dy == '0) ||
                        (dx == ball_last) || (dy == ball_last);

        always_comb begin
                if (!in_ball)
                        color.raw = color_black;
                else if (on_rim)
                        color.raw = color_red;
                else
                        color.raw = color_white;
        end

        assign hit = in_ball;

endmodule

// ==== verilog/pixel_mixer.sv ====
`timescale 1ns/1ns

module pixel_mixer
        import pong_pkg::*;
(
        input  logic         clk,
        input  logic         rst_n,
        raster_if.sink       raster,
        input  logic         ball_hit,
        input  pixel_color_u ball_color,
        input  logic         left_hit,
        input  pixel_color_u left_color,
        input  logic         right_hit,
        input  pixel_color_u right_color,
        output logic [7:0]   red,
        output logic [7:0]   green,
        output logic [7:0]   blue,
        output logic         hsync,
        output logic         vsync,
        output logic         de
);

        pixel_color_u sel_color;
        pixel_color_u out_color;

        // ball first, then left paddle, then right paddle
        always_comb begin
                if (!raster.active)
                        sel_color.raw = color_black;
                else if (ball_hit)
                        sel_color = ball_color;
                else if (left_hit)
                        sel_color = left_color;
                else if (right_hit)
                        sel_color = right_color;
                else
                        sel_color.raw = color_black;
        end

        // one register stage keeps colour, syncs and de together
        always_ff @(posedge clk or negedge rst_n) begin
                if (!rst_n) begin
                        out_color.raw <= color_black;
                        hsync         <= 1'b1;
                        vsync         <= 1'b1;
                        de            <= 1'b0;
                end else begin
                        out_color     <= sel_color;
                        hsync         <= raster.hsync;
                        vsync         <= raster.vsync;
                        de            <= raster.active;
                end
        end

        assign red   = out_color.rgb.red;
        assign green = out_color.rgb.green;
        assign blue  = out_color.rgb.blue;

        // nothing may leak into the blanking interval
        a_black_in_blank: assert property (@(posedge clk)
                !de |-> ({red, green, blue} == color_black));

endmodule

// ==== verilog/pong_display.sv ====
`timescale 1ns/1ns

module pong_display
        import pong_pkg::*;
#(
        parameter int h_active  = 640,
        parameter int h_front   = 16,
        parameter int h_sync    = 96,
        parameter int h_back    = 48,
        parameter int v_active  = 480,
        parameter int v_front   = 10,
        parameter int v_sync    = 2,
        parameter int v_back    = 33,
        parameter int ball_size = 8
) (
        input  logic               clk,
        input  logic               rst_n,
        input  logic [coord_w-1:0] paddle_left_x,
        input  logic [coord_w-1:0] paddle_left_y,
        input  logic [coord_w-1:0] paddle_right_x,
        input  logic [coord_w-1:0] paddle_right_y,
        input  logic [coord_w-1:0] ball_x,
        input  logic [coord_w-1:0] ball_y,
        output logic [7:0]         red,
        output logic [7:0]         green,
        output logic [7:0]         blue,
        output logic               hsync,
        output logic               vsync,
        output logic               de
);

        logic         ball_hit;
        logic         left_hit;
        logic         right_hit;
        pixel_color_u ball_color;
        pixel_color_u left_color;
        pixel_color_u right_color;

        raster_if u_raster ();

        vga_timing #(
                .h_active (h_active),
                .h_front  (h_front),
                .h_sync   (h_sync),
                .h_back   (h_back),
                .v_active (v_active),
                .v_front  (v_front),
                .v_sync   (v_sync),
                .v_back   (v_back)
        ) u_timing (
                .clk    (clk),
                .rst_n  (rst_n),
                .raster (u_raster.source)
        );

        paddle_sprite u_paddle_left (
                .raster (u_raster.sink),
                .pos_x  (paddle_left_x),
                .pos_y  (paddle_left_y),
                .hit    (left_hit),
                .color  (left_color)
        );

        paddle_sprite u_paddle_right (
                .raster (u_raster.sink),
                .pos_x  (paddle_right_x),
                .pos_y  (paddle_right_y),
                .hit    (right_hit),
                .color  (right_color)
        );

        ball_sprite #(
                .ball_size (ball_size)
        ) u_ball (
                .raster (u_raster.sink),
                .pos_x  (ball_x),
                .pos_y  (ball_y),
                .hit    (ball_hit),
                .color  (ball_color)
        );

        pixel_mixer u_mixer (
                .clk         (clk),
                .rst_n       (rst_n),
                .raster      (u_raster.sink),
                .ball_hit    (ball_hit),
                .ball_color  (ball_color),
                .left_hit    (left_hit),
                .left_color  (left_color),
                .right_hit   (right_hit),
                .right_color (right_color),
                .red         (red),
                .green       (green),
                .blue        (blue),
                .hsync       (hsync),
                .vsync       (vsync),
                .de          (de)
        );

endmodule

// ==== testbench/pong_checker.sv ====
`timescale 1ns/1ns

module pong_checker
        import pong_pkg::*;
#(
        parameter int h_active  = 160,
        parameter int h_front   = 4,
        parameter int h_sync    = 8,
        parameter int h_back    = 4,
        parameter int v_active  = 100,
        parameter int v_front   = 2,
        parameter int v_sync    = 2,
        parameter int v_back    = 2,
        parameter int ball_size = 8
) (
        input logic               clk,
        input logic               rst_n,
        input logic [7:0]         red,
        input logic [7:0]         green,
        input logic [7:0]         blue,
        input logic               hsync,
        input logic               vsync,
        input logic               de,
        input logic [coord_w-1:0] paddle_left_x,
        input logic [coord_w-1:0] paddle_left_y,
        input logic [coord_w-1:0] paddle_right_x,
        input logic [coord_w-1:0] paddle_right_y,
        input logic [coord_w-1:0] ball_x,
        input logic [coord_w-1:0] ball_y
);

        localparam int h_total = h_active + h_front + h_sync + h_back;
        localparam int v_total = v_active + v_front + v_sync + v_back;
        localparam int span_x  = 101;
        localparam int span_y  = 75;

        int  mismatch_count = 0;
        int  other_count = 0;
        int  checked_count = 0;
        int  cx = 0;
        int  cy = 0;
        int  sx;
        int  sy;
        int  snap[0:5];
        bit  snap_valid = 0;
        // colour bit seen at each box offset of each paddle or 0 if not seen
        byte art[0:1][0:span_x][0:span_y];

        // one bit per palette colour so that a set of allowed colours is a mask
        function automatic int color_bit(input logic [23:0] c);
                case (c)
                        24'h000000: return 1;
                        24'h0000ff: return 2;
                        24'hd3d3d3: return 4;
                        24'hff0000: return 8;
                        24'hffffff: return 16;
                        default:    return 0;
                endcase
        endfunction

        // 0 outside the box, 1 body, 2 bevelled corner that may stay clear
        function automatic int paddle_zone(input int x, input int y, input int px, input int py);
                int dx;
                int dy;
                int fx;
                int fy;
                dx = x - px;
                dy = y - py;
                if (dx < 0 || dy < 0 || dx > span_x || dy > span_y)
                        return 0;
                fx = (dx <= 51) ? dx : span_x - dx;
                fy = (dy <= 38) ? dy : span_y - dy;
                if (fx <= 5 && fy <= 5)
                        return 2;
                return 1;
        endfunction

        function automatic bit in_ball(input int x, input int y, input int bx, input int by);
                return x >= bx && x - bx < ball_size && y >= by && y - by < ball_size;
        endfunction

        // allowed colours for one pixel with layers from the bottom up
        function automatic int expected_mask(input int x, input int y, input int p[0:5]);
                int m;
                int z;
                int dx;
                int dy;
                if (!(x < h_active && y < v_active))
                        return 1;
                m = 1;
                z = paddle_zone(x, y, p[2], p[3]);
                m = (z == 1) ? 6 : (z == 2) ? (m | 6) : m;
                z = paddle_zone(x, y, p[0], p[1]);
                m = (z == 1) ? 6 : (z == 2) ? (m | 6) : m;
                if (in_ball(x, y, p[4], p[5])) begin
                        dx = x - p[4];
                        dy = y - p[5];
                        if (dx == 0 || dy == 0 || dx == ball_size - 1 || dy == ball_size - 1)
                                m = 8;
                        else
                                m = 16;
                end
                return m;
        endfunction

        // a paddle looks the same after mirroring across either axis
        task automatic check_symmetry();
                for (int p = 0; p < 2; p++) begin
                        for (int dx = 0; dx <= span_x; dx++) begin
                                for (int dy = 0; dy <= span_y; dy++) begin
                                        if (art[p][dx][dy] != 0 &&
                                            art[p][span_x-dx][dy] != 0 &&
                                            art[p][dx][dy] != art[p][span_x-dx][dy]) begin
                                                other_count++;
                                                $display("paddle %0d not mirrored in x at %0d,%0d",
                                                         p, dx, dy);
                                        end
                                        if (art[p][dx][dy] != 0 &&
                                            art[p][dx][span_y-dy] != 0 &&
                                            art[p][dx][dy] != art[p][dx][span_y-dy]) begin
                                                other_count++;
                                                $display("paddle %0d not mirrored in y at %0d,%0d",
                                                         p, dx, dy);
                                        end
                                        art[p][dx][dy] = 0;
                                end
                        end
                end
        endtask

        // the raster position and sprite positions seen by this edge
        always @(posedge clk) begin
                if (rst_n) begin
                        sx = cx;
                        sy = cy;
                        snap[0] = int'(paddle_left_x);
                        snap[1] = int'(paddle_left_y);
                        snap[2] = int'(paddle_right_x);
                        snap[3] = int'(paddle_right_y);
                        snap[4] = int'(ball_x);
                        snap[5] = int'(ball_y);
                        snap_valid = 1;
                        cx = (cx == h_total - 1) ? 0 : cx + 1;
                        if (sx == h_total - 1)
                                cy = (cy == v_total - 1) ? 0 : cy + 1;
                end
        end

        always @(negedge clk) begin
                bit exp_de;
                bit exp_hs;
                bit exp_vs;
                int m;
                int got;
                int zl;
                int zr;
                if (!rst_n) begin
                        if (hsync !== 1'b1 || vsync !== 1'b1 || de !== 1'b0 ||
                            {red, green, blue} !== 24'h0) begin
                                other_count++;
                                $display("outputs not at reset values at %0t", $time);
                        end
                end else if (snap_valid) begin
                        exp_de = sx < h_active && sy < v_active;
                        exp_hs = !(sx >= h_active + h_front && sx < h_active + h_front + h_sync);
                        exp_vs = !(sy >= v_active + v_front && sy < v_active + v_front + v_sync);
                        m = expected_mask(sx, sy, snap);
                        got = color_bit({red, green, blue});
                        checked_count++;
                        if (de !== exp_de) begin
                                mismatch_count++;
                                $display("MISMATCH t=%0t de expected=%0b got=%0b", $time, exp_de, de);
                        end
                        if (hsync !== exp_hs) begin
                                mismatch_count++;
                                $display("MISMATCH t=%0t hsync expected=%0b got=%0b",
                                         $time, exp_hs, hsync);
                        end
                        if (vsync !== exp_vs) begin
                                mismatch_count++;
                                $display("MISMATCH t=%0t vsync expected=%0b got=%0b",
                                         $time, exp_vs, vsync);
                        end
                        if ((got & m) == 0) begin
                                mismatch_count++;
                                $display("MISMATCH t=%0t rgb at %0d,%0d expected mask=%05b got=%06h",
                                         $time, sx, sy, m[4:0], {red, green, blue});
                        end
                        zl = paddle_zone(sx, sy, snap[0], snap[1]);
                        zr = paddle_zone(sx, sy, snap[2], snap[3]);
                        // the left body wins over the right paddle, so it is
                        // recorded on top of it too
                        if (exp_de && !in_ball(sx, sy, snap[4], snap[5])) begin
                                if (zl == 1 || (zl == 2 && zr == 0))
                                        art[0][sx-snap[0]][sy-snap[1]] = byte'(got);
                                if (zr != 0 && zl == 0)
                                        art[1][sx-snap[2]][sy-snap[3]] = byte'(got);
                        end
                        if (sx == h_total - 1 && sy == v_total - 1)
                                check_symmetry();
                end
        end

endmodule

// ==== testbench/tb_pong_display.sv ====
`timescale 1ns/1ns

module tb_pong_display
        import pong_pkg::*;
();

        logic               clk;
        logic               rst_n;
        logic [coord_w-1:0] paddle_left_x;
        logic [coord_w-1:0] paddle_left_y;
        logic [coord_w-1:0] paddle_right_x;
        logic [coord_w-1:0] paddle_right_y;
        logic [coord_w-1:0] ball_x;
        logic [coord_w-1:0] ball_y;
        logic [7:0]         red;
        logic [7:0]         green;
        logic [7:0]         blue;
        logic               hsync;
        logic               vsync;
        logic               de;

        logic [31:0] lfsr_state = 32'h247b;
        int          timeout_count = 0;

        pong_display #(
                .h_active (160), .h_front (4), .h_sync (8), .h_back (4),
                .v_active (100), .v_front (2), .v_sync (2), .v_back (2),
                .ball_size (8)
        ) i_pong_display (
                .clk (clk), .rst_n (rst_n),
                .paddle_left_x (paddle_left_x), .paddle_left_y (paddle_left_y),
                .paddle_right_x (paddle_right_x), .paddle_right_y (paddle_right_y),
                .ball_x (ball_x), .ball_y (ball_y),
                .red (red), .green (green), .blue (blue),
                .hsync (hsync), .vsync (vsync), .de (de)
        );

        pong_checker i_checker (
                .clk (clk), .rst_n (rst_n),
                .red (red), .green (green), .blue (blue),
                .hsync (hsync), .vsync (vsync), .de (de),
                .paddle_left_x (paddle_left_x), .paddle_left_y (paddle_left_y),
                .paddle_right_x (paddle_right_x), .paddle_right_y (paddle_right_y),
                .ball_x (ball_x), .ball_y (ball_y)
        );

        initial begin
                clk = 1'b0;
                forever #5 clk = ~clk;
        end

        // fibonacci lfsr with taps 32 22 2 1 stepped once per bit
        function automatic logic [15:0] take_bits(input int n);
                logic [15:0] v;
                v = '0;
                for (int i = 0; i < n; i++) begin
                        lfsr_state = {lfsr_state[30:0],
                                      lfsr_state[31] ^ lfsr_state[21] ^
                                      lfsr_state[1] ^ lfsr_state[0]};
                        v = {v[14:0], lfsr_state[0]};
                end
                return v;
        endfunction

        // frame boundary seen as a falling vsync
        task automatic wait_vsync_fall();
                int n;
                n = 0;
                while (vsync !== 1'b1 && n < 40000) begin
                        @(posedge clk);
                        n++;
                end
                while (vsync !== 1'b0 && n < 40000) begin
                        @(posedge clk);
                        n++;
                end
                if (n >= 40000) begin
                        timeout_count++;
                        $display("timeout waiting for vertical sync");
                end
        endtask

        task automatic set_positions(input int lx, input int ly, input int rx, input int ry,
                                     input int bx, input int by);
                @(posedge clk);
                #1;
                paddle_left_x  = coord_w'(lx);
                paddle_left_y  = coord_w'(ly);
                paddle_right_x = coord_w'(rx);
                paddle_right_y = coord_w'(ry);
                ball_x         = coord_w'(bx);
                ball_y         = coord_w'(by);
        endtask

        initial begin
                rst_n = 1'b0;
                // left paddle alone
                paddle_left_x  = 16'd10;
                paddle_left_y  = 16'd10;
                paddle_right_x = 16'd400;
                paddle_right_y = 16'd300;
                ball_x         = 16'd500;
                ball_y         = 16'd500;
                repeat (16) @(posedge clk);
                #1;
                rst_n = 1'b1;
                wait_vsync_fall();
                // right paddle alone with the ball
                set_positions(400, 300, 40, 20, 5, 90);
                wait_vsync_fall();
                // ball over both paddles
                set_positions(10, 10, 60, 20, 55, 30);
                wait_vsync_fall();
                // left corner over the right paddle
                set_positions(30, 10, 20, 5, 130, 8);
                for (int f = 0; f < 4; f++) begin
                        wait_vsync_fall();
                        set_positions(take_bits(8), take_bits(7), take_bits(8), take_bits(7),
                                      take_bits(8), take_bits(7));
                end
                wait_vsync_fall();
                wait_vsync_fall();
                if (i_checker.checked_count < 18656) begin
                        timeout_count++;
                        $display("checker saw fewer pixels than one frame");
                end
                $display("errors: mismatch=%0d other=%0d timeout=%0d",
                         i_checker.mismatch_count, i_checker.other_count, timeout_count);
                if (i_checker.mismatch_count == 0 && i_checker.other_count == 0 &&
                    timeout_count == 0) begin
                        $display("*** PASSED ***");
                end else begin
                        $display("*** FAILED ***");
                end
                $finish;
        end

endmodule

// ==== files.f ====
verilog/pong_pkg.sv
verilog/raster_if.sv
verilog/vga_timing.sv
verilog/paddle_sprite.sv
verilog/ball_sprite.sv
verilog/pixel_mixer.sv
verilog/pong_display.sv
testbench/pong_checker.sv
testbench/tb_pong_display.sv

// ==== Makefile ====
SRCS := $(shell cat files.f)

.PHONY: all run clean

all: obj_dir/Vtb_pong_display

obj_dir/V%: $(SRCS) files.f
	verilator --binary --timing --assert -Wno-fatal -f files.f --top-module $* -o V$*

run: obj_dir/Vtb_pong_display
	./obj_dir/Vtb_pong_display | tee sim.log
	grep -q '\*\*\* PASSED \*\*\*' sim.log

clean:
	rm -rf obj_dir sim.log
